//--- all.f
rtl/ls_pkg.sv
rtl/ls_ifs.sv
rtl/ls_decode.sv
rtl/lsu.sv
rtl/csr_unit.sv
rtl/ls_result_merge.sv
rtl/ls_stage.sv
tests/ls_checker.sv
tests/tb_ls_stage.sv

//--- tests/tb_ls_stage.sv
`timescale 1ns/100ps

module tb_ls_stage import ls_pkg::*; ();
    localparam int          XLEN       = 64;
    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 16;
    localparam logic [63:0] MEM_BASE   = 64'h1000;
    localparam logic [63:0] ERR_BASE   = 64'h8000;  // Slave answers with an error from here up
    localparam int          N_STORE    = 16;
    localparam int          N_MIX      = 40;
    localparam int          N_INSTR    = N_STORE * 8 + N_MIX + 35 + 12 + 14;

    logic              clk          = 1'b0;
    logic              rst_i        = 1'b1;
    logic              in_valid_i   = 1'b0;
    logic [XLEN-1:0]   pc_i         = '0;
    logic [XLEN-1:0]   addr_i       = '0;
    logic [XLEN-1:0]   rs2_i        = '0;
    logic [31:0]       instr_i      = '0;
    logic              trap_i       = 1'b0;
    logic [XLEN-1:0]   trap_cause_i = '0;
    logic [XLEN-1:0]   prdata_i     = '0;
    logic              pready_i     = 1'b0;
    logic              pslverr_i    = 1'b0;
    logic              in_ready_o;
    logic              res_valid_o;
    logic              res_err_o;
    logic [XLEN-1:0]   res_data_o;
    logic [XLEN-1:0]   mtvec_o;
    logic [XLEN-1:0]   mepc_o;
    logic [XLEN-1:0]   paddr_o;
    logic [XLEN-1:0]   pwdata_o;
    logic [XLEN/8-1:0] pstrb_o;
    logic              psel_o;
    logic              penable_o;
    logic              pwrite_o;
    logic              apb_end;
    logic              chk_busy;
    int                err_cnt;
    int                err_mark;
    int                n_issued;
    logic [XLEN-1:0]   ram [64];
    logic [5:0]        ram_idx;
    int                waits;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ls_stage #(.XLEN(XLEN)) u_dut (.*);

    assign apb_end = psel_o && penable_o && pready_i;

    ls_checker #(.XLEN(XLEN), .MEM_BASE(MEM_BASE), .ERR_BASE(ERR_BASE)) u_chk (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_i  (in_ready_o),
        .pc_i        (pc_i),
        .addr_i      (addr_i),
        .rs2_i       (rs2_i),
        .instr_i     (instr_i),
        .trap_i      (trap_i),
        .cause_i     (trap_cause_i),
        .res_valid_i (res_valid_o),
        .res_err_i   (res_err_o),
        .res_data_i  (res_data_o),
        .mtvec_i     (mtvec_o),
        .mepc_i      (mepc_o),
        .apb_end_i   (apb_end),
        .pwrite_i    (pwrite_o),
        .pstrb_i     (pstrb_o),
        .psel_i      (psel_o),
        .penable_i   (penable_o),
        .paddr_i     (paddr_o),
        .pwdata_i    (pwdata_o),
        .busy_o      (chk_busy),
        .err_cnt_o   (err_cnt)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // APB memory
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [XLEN-1:0] fill_word(logic [63:0] a);
        return {a[63:32] ^ a[31:0] ^ 32'hC3A5_5A3C, ~a[31:0]};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            ram[i] = fill_word(MEM_BASE + 64'(8 * i));
        end
    end

    assign ram_idx = paddr_o[8:3];

    always @(posedge clk) begin
        if (rst_i) begin
            pready_i  <= 1'b0;
            pslverr_i <= 1'b0;
            waits      = 0;
        end else if (apb_end) begin
            if (pwrite_o && !pslverr_i) begin
                for (int b = 0; b < XLEN / 8; b++) begin
                    if (pstrb_o[b]) begin
                        ram[ram_idx][8*b +: 8] = pwdata_o[8*b +: 8];
                    end
                end
            end
            pready_i  <= 1'b0;
            pslverr_i <= 1'b0;
        end else if (psel_o) begin
            waits = penable_o ? waits - 1 : int'($urandom_range(3, 0));  // Wait states
            if (waits <= 0) begin
                pready_i  <= 1'b1;
                pslverr_i <= (paddr_o >= ERR_BASE);
                prdata_i  <= ram[ram_idx];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] encode(logic [4:0] opc, logic [2:0] f3, logic [11:0] csr,
                                           logic [4:0] rs1);
        return {csr, rs1, f3, 5'd1, opc, 2'b11};
    endfunction

    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // Random address aligned to the access size
    function automatic logic [63:0] mem_addr(logic [2:0] f3, logic [63:0] base);
        return base + (64'($urandom_range(511, 0)) & ~((64'd1 << f3[1:0]) - 64'd1));
    endfunction

    task automatic issue(input logic [31:0] instr, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] rs2, input logic trap,
                         input logic [XLEN-1:0] cause);
        in_valid_i   <= 1'b1;
        instr_i      <= instr;
        pc_i         <= rand_word();
        addr_i       <= addr;
        rs2_i        <= rs2;
        trap_i       <= trap;
        trap_cause_i <= cause;
        do begin
            @(posedge clk);
        end while (!in_ready_o);
        in_valid_i <= 1'b0;
        trap_i     <= 1'b0;
        n_issued++;
    endtask

    task automatic end_test(input int num, input string name);
        @(posedge clk);
        while (chk_busy) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("test %0d %s: %0d errors", num, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    initial begin
        logic [63:0] addrs [N_STORE];
        logic [11:0] csrs [5];
        logic [2:0]  csr_f3 [6];
        logic [63:0] a;
        logic [2:0]  f3;
        logic [4:0]  opc;
        void'($urandom(68696));
        csrs   = '{CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MSCRATCH, 12'h7C0};
        csr_f3 = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
        repeat (RST_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < N_STORE; i++) begin
            f3       = 3'($urandom_range(3, 0));
            addrs[i] = mem_addr(f3, MEM_BASE);
            issue(encode(OP_STORE, f3, 12'h000, 5'd0), addrs[i], rand_word(), 1'b0, '0);
        end
        for (int i = 0; i < N_STORE; i++) begin
            for (int k = 0; k < 7; k++) begin
                f3 = 3'(k);
                a  = addrs[i] & ~((64'd1 << f3[1:0]) - 64'd1);
                issue(encode(OP_LOAD, f3, 12'h000, 5'd0), a, rand_word(), 1'b0, '0);
            end
        end
        end_test(1, "store then load");

        for (int i = 0; i < N_MIX; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                f3  = 3'($urandom_range(3, 0));
                opc = OP_STORE;
            end else begin
                f3  = 3'($urandom_range(6, 0));
                opc = OP_LOAD;
            end
            issue(encode(opc, f3, 12'h000, 5'd0), mem_addr(f3, MEM_BASE), rand_word(), 1'b0, '0);
        end
        end_test(2, "wait states");

        foreach (csrs[c]) begin
            foreach (csr_f3[k]) begin
                a = ($urandom_range(3, 0) == 0) ? 64'd0 : rand_word();
                issue(encode(OP_SYSTEM, csr_f3[k], csrs[c], 5'($urandom)), a, '0, 1'b0, '0);
            end
        end
        foreach (csrs[c]) begin
            issue(encode(OP_SYSTEM, 3'd6, csrs[c], 5'd0), '0, '0, 1'b0, '0);  // Plain read
        end
        end_test(3, "csr access");

        for (int i = 0; i < 4; i++) begin
            issue(32'h0, '0, '0, 1'b1, rand_word());
            issue(encode(OP_SYSTEM, 3'd6, CSR_MCAUSE, 5'd0), '0, '0, 1'b0, '0);
            issue(encode(OP_SYSTEM, 3'd6, CSR_MEPC, 5'd0), '0, '0, 1'b0, '0);
        end
        end_test(4, "trap");

        for (int i = 0; i < 6; i++) begin
            opc = 5'($urandom);
            if (opc == OP_LOAD || opc == OP_STORE || opc == OP_SYSTEM) begin
                opc = 5'b01100;  // Register ALU opcodes never reach this stage
            end
            issue(encode(opc, 3'($urandom), 12'h000, 5'd0), rand_word(), rand_word(), 1'b0, '0);
        end
        for (int i = 0; i < 2; i++) begin
            issue(encode(OP_LOAD, 3'd7, 12'h000, 5'd0), MEM_BASE, '0, 1'b0, '0);
        end
        for (int i = 0; i < 6; i++) begin
            f3  = 3'($urandom_range(3, 0));
            opc = (i % 2 == 1) ? OP_STORE : OP_LOAD;
            issue(encode(opc, f3, 12'h000, 5'd0), mem_addr(f3, ERR_BASE), rand_word(), 1'b0, '0);
        end
        end_test(5, "illegal and slave error");

        $display("5 tests, %0d instructions, %0d errors", n_issued, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Ten cycles per instruction is well above the slowest access
    initial begin
        #(CLK_PERIOD * (N_INSTR * 10 + RST_CYCLES));
        $display("Run timed out because the DUT stopped accepting or answering instructions");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- tests/ls_checker.sv
`timescale 1ns/100ps

module ls_checker import ls_pkg::*; #(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] MEM_BASE = 'h1000,
    parameter logic [XLEN-1:0] ERR_BASE = 'h8000
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              in_valid_i,
    input  logic              in_ready_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   addr_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic [31:0]       instr_i,
    input  logic              trap_i,
    input  logic [XLEN-1:0]   cause_i,
    input  logic              res_valid_i,
    input  logic              res_err_i,
    input  logic [XLEN-1:0]   res_data_i,
    input  logic [XLEN-1:0]   mtvec_i,
    input  logic [XLEN-1:0]   mepc_i,
    input  logic              apb_end_i,  // Last cycle of an APB transfer
    input  logic              pwrite_i,
    input  logic [XLEN/8-1:0] pstrb_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic [XLEN-1:0]   paddr_i,
    input  logic [XLEN-1:0]   pwdata_i,
    output logic              busy_o,
    output int                err_cnt_o
);
    localparam int NB = XLEN / 8;

    logic [XLEN-1:0] mem_m [64];
    logic [XLEN-1:0] csr_m [4];  // mtvec, mepc, mcause, mscratch
    logic [XLEN-1:0] exp_data;
    logic [NB-1:0]   exp_strb;
    logic [XLEN-1:0] exp_paddr;
    logic [XLEN-1:0] exp_wdata;
    logic [XLEN-1:0] exp_wmask;
    logic            exp_err;
    logic            exp_store;
    logic            pend;
    logic            pend_mem;
    int              cyc;
    int              acc_cyc;
    int              exp_cyc;
    int              ready_cyc;
    int              mepc_cyc;

    function automatic logic [XLEN-1:0] fill_word(logic [63:0] a);
        return XLEN'({a[63:32] ^ a[31:0] ^ 32'hC3A5_5A3C, ~a[31:0]});
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem_m[i] = fill_word(MEM_BASE + XLEN'(NB * i));
        end
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] got);
        if (got !== exp) begin
            $display("error %s exp=%0h got=%0h", name, exp, got);
            err_cnt_o++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_cnt_o++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic take_instr();
        logic [4:0]      opc;
        logic [2:0]      f3;
        logic [11:0]     csr_addr;
        logic [XLEN-1:0] opnd;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] nv;
        logic [XLEN-1:0] t;
        int              k;
        int              nb;
        int              lane;
        int              idx;
        int              sh;
        opc = instr_i[6:2];
        f3  = instr_i[14:12];
        if (trap_i) begin
            csr_m[1]  = {pc_i[XLEN-1:1], 1'b0};
            csr_m[2]  = cause_i;
            mepc_cyc  = cyc + 1;
            ready_cyc = cyc + 1;  // No result comes and the stage is free again at once
            return;
        end
        pend     = 1'b1;
        busy_o  <= 1'b1;
        pend_mem = 1'b0;
        exp_err  = 1'b0;
        exp_data = '0;
        exp_cyc  = -1;
        if ((opc != OP_LOAD && opc != OP_STORE && opc != OP_SYSTEM) ||
            (opc == OP_LOAD && f3 == 3'd7) ||
            (XLEN == 32 && opc != OP_SYSTEM && (f3 == MEM_D || f3 == MEM_WU))) begin
            exp_err = 1'b1;
            exp_cyc = cyc + 1;
        end else if (opc == OP_SYSTEM) begin
            csr_addr = instr_i[31:20];
            opnd     = f3[2] ? XLEN'(instr_i[19:15]) : addr_i;
            k = (csr_addr == CSR_MTVEC)  ? 0 : (csr_addr == CSR_MEPC)     ? 1 :
                (csr_addr == CSR_MCAUSE) ? 2 : (csr_addr == CSR_MSCRATCH) ? 3 : -1;
            old      = (k < 0) ? '0 : csr_m[k];
            exp_data = old;
            case (f3[1:0])
                2'd1:    nv = opnd;
                2'd2:    nv = old | opnd;
                default: nv = old & ~opnd;
            endcase
            if (k >= 0 && (f3[1:0] == 2'd1 || opnd != '0)) begin
                if (k == 0) begin
                    nv[1:0] = 2'b00;
                end
                if (k == 1) begin
                    nv[0] = 1'b0;
                end
                csr_m[k] = nv;
            end
            exp_cyc = cyc + 2;
        end else begin
            pend_mem  = 1'b1;
            acc_cyc   = cyc;
            exp_store = (opc == OP_STORE);
            nb        = 1 << f3[1:0];
            lane      = addr_i % NB;
            idx       = ((addr_i - MEM_BASE) / NB) % 64;
            exp_strb  = NB'(((1 << nb) - 1) << lane);
            exp_paddr = addr_i & ~XLEN'(NB - 1);
            exp_wdata = '0;
            exp_wmask = '0;
            for (int b = 0; b < nb; b++) begin
                exp_wdata[8*(lane+b) +: 8] = rs2_i[8*b +: 8];
                exp_wmask[8*(lane+b) +: 8] = 8'hFF;
            end
            if (addr_i >= ERR_BASE) begin
                exp_err = 1'b1;
            end else if (exp_store) begin
                mem_m[idx] = (mem_m[idx] & ~exp_wmask) | exp_wdata;
            end else begin
                sh = XLEN - 8 * nb;
                t  = (mem_m[idx] >> (8 * lane)) << sh;
                if (f3[2]) begin
                    exp_data = t >> sh;
                end else begin
                    exp_data = $signed(t) >>> sh;
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Port watch
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (rst_i) begin
            csr_m     = '{default: '0};
            pend      = 1'b0;
            busy_o   <= 1'b0;
            cyc       = 0;
            exp_cyc   = -1;
            ready_cyc = -1;
            mepc_cyc  = -1;
        end else begin
            cyc++;
            if (pend && in_ready_i) begin
                report_failure("in_ready_o is high while an instruction is in flight");
            end
            if (cyc == ready_cyc && !in_ready_i) begin
                report_failure("in_ready_o did not rise after the instruction finished");
            end
            if (cyc == mepc_cyc) begin
                check_value("mepc_o", csr_m[1], mepc_i);
            end
            // SETUP on the first cycle after acceptance, ACCESS from the second
            if (pend && pend_mem && exp_cyc < 0) begin
                check_value("psel_o", 1'b1, psel_i);
                check_value("penable_o", cyc > acc_cyc + 1, penable_i);
            end else if (psel_i) begin
                report_failure("psel_o is high with no memory access waiting");
            end
            if (apb_end_i) begin
                if (!pend || !pend_mem) begin
                    report_failure("APB transfer without a memory instruction");
                end else begin
                    check_value("paddr_o", exp_paddr, paddr_i);
                    check_value("pwrite_o", exp_store, pwrite_i);
                    if (pwrite_i) begin
                        check_value("pstrb_o", exp_strb, pstrb_i);
                        check_value("pwdata_o", exp_wdata, pwdata_i & exp_wmask);
                    end
                    exp_cyc = cyc + 1;
                end
            end
            if (res_valid_i) begin
                if (!pend) begin
                    report_failure("result came out with no instruction in flight");
                end else begin
                    if (cyc != exp_cyc) begin
                        report_failure($sformatf("result at cycle %0d, expected at cycle %0d",
                                                 cyc, exp_cyc));
                    end
                    check_value("res_err_o", exp_err, res_err_i);
                    check_value("res_data_o", exp_data, res_data_i);
                    check_value("mtvec_o", csr_m[0], mtvec_i);
                    check_value("mepc_o", csr_m[1], mepc_i);
                    pend      = 1'b0;
                    busy_o   <= 1'b0;
                    ready_cyc = cyc + 1;
                end
            end
            if (in_valid_i && in_ready_i) begin
                take_instr();
            end
        end
    end

endmodule

//--- rtl/ls_stage.sv
`timescale 1ns/100ps

module ls_stage import ls_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_i,
    // Instruction side
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   addr_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic [31:0]       instr_i,
    input  logic              trap_i,
    input  logic [XLEN-1:0]   trap_cause_i,
    // Writeback side
    output logic              res_valid_o,
    output logic              res_err_o,
    output logic [XLEN-1:0]   res_data_o,
    output logic [XLEN-1:0]   mtvec_o,
    output logic [XLEN-1:0]   mepc_o,
    // APB master to data memory
    output logic [XLEN-1:0]   paddr_o,
    output logic [XLEN-1:0]   pwdata_o,
    output logic [XLEN/8-1:0] pstrb_o,
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    input  logic [XLEN-1:0]   prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i
);
    logic illegal;
    logic res_done;

    mem_req_if #(.XLEN(XLEN)) u_mem_if ();
    csr_req_if #(.XLEN(XLEN)) u_csr_if ();

    ls_decode #(.XLEN(XLEN)) u_decode (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .pc_i         (pc_i),
        .addr_i       (addr_i),
        .rs2_i        (rs2_i),
        .instr_i      (instr_i),
        .trap_i       (trap_i),
        .trap_cause_i (trap_cause_i),
        .res_done_i   (res_done),
        .illegal_o    (illegal),
        .mem          (u_mem_if.decode),
        .csr          (u_csr_if.decode)
    );

    lsu #(.XLEN(XLEN)) u_lsu (
        .clk       (clk),
        .rst_i     (rst_i),
        .mem       (u_mem_if.lsu),
        .paddr_o   (paddr_o),
        .pwdata_o  (pwdata_o),
        .pstrb_o   (pstrb_o),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .pwrite_o  (pwrite_o),
        .prdata_i  (prdata_i),
        .pready_i  (pready_i),
        .pslverr_i (pslverr_i)
    );

    csr_unit #(.XLEN(XLEN)) u_csr (
        .clk     (clk),
        .rst_i   (rst_i),
        .csr     (u_csr_if.csr),
        .mtvec_o (mtvec_o),
        .mepc_o  (mepc_o)
    );

    ls_result_merge #(.XLEN(XLEN)) u_merge (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem         (u_mem_if.merge),
        .csr         (u_csr_if.merge),
        .illegal_i   (illegal),
        .res_valid_o (res_valid_o),
        .res_err_o   (res_err_o),
        .res_data_o  (res_data_o),
        .res_done_o  (res_done)
    );

endmodule

//--- rtl/ls_result_merge.sv
`timescale 1ns/100ps

module ls_result_merge import ls_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_i,
    mem_req_if.merge        mem,
    csr_req_if.merge        csr,
    input  logic            illegal_i,
    output logic            res_valid_o,
    output logic            res_err_o,
    output logic [XLEN-1:0] res_data_o,
    output logic            res_done_o
);
    logic            any_done;
    logic            mem_fail;
    logic [XLEN-1:0] next_data;

    assign any_done = mem.done || csr.done || illegal_i;
    assign mem_fail = mem.done && mem.err;

    // Only one unit can finish in a cycle since one instruction is in flight
    always_comb begin
        if (mem.done) begin
            next_data = mem_fail ? '0 : mem.rdata;
        end else if (csr.done) begin
            next_data = csr.rdata;
        end else begin
            next_data = '0;  // Illegal instruction
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
            res_err_o   <= 1'b0;
        end else begin
            res_valid_o <= any_done;
            res_err_o   <= mem_fail || illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            res_data_o <= next_data;
        end
    end

    assign res_done_o = res_valid_o;  // Frees the decoder for the next instruction

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/100ps

module csr_unit import ls_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_i,
    csr_req_if.csr          csr,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic            addr_hit;
    logic            wr_en;

    // ~~~~~~~~~~~~~~~~~~~~
    // Read and modify
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        addr_hit = 1'b1;
        case (csr.addr)
            CSR_MTVEC:    old_val = mtvec_q;
            CSR_MEPC:     old_val = mepc_q;
            CSR_MCAUSE:   old_val = mcause_q;
            CSR_MSCRATCH: old_val = mscratch_q;
            default: begin
                old_val  = '0;
                addr_hit = 1'b0;  // Unimplemented CSR reads as zero
            end
        endcase
    end

    always_comb begin
        case (csr.op)
            CSR_RW:  new_val = csr.wdata;
            CSR_RS:  new_val = old_val | csr.wdata;
            CSR_RC:  new_val = old_val & ~csr.wdata;
            default: new_val = old_val;
        endcase
    end

    // Set or clear with a zero operand leaves the register alone
    assign wr_en = csr.valid && addr_hit &&
                   (csr.op == CSR_RW ||
                    ((csr.op == CSR_RS || csr.op == CSR_RC) && csr.wdata != '0));

    // ~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (csr.trap) begin
            mepc_q   <= {csr.pc[XLEN-1:1], 1'b0};
            mcause_q <= csr.cause;
        end else if (wr_en) begin
            case (csr.addr)
                CSR_MTVEC:    mtvec_q    <= {new_val[XLEN-1:2], 2'b00};  // Direct mode only
                CSR_MEPC:     mepc_q     <= {new_val[XLEN-1:1], 1'b0};
                CSR_MCAUSE:   mcause_q   <= new_val;
                CSR_MSCRATCH: mscratch_q <= new_val;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            csr.done <= 1'b0;
        end else begin
            csr.done <= csr.valid;
        end
    end

    // The value before the write goes back as the result
    always_ff @(posedge clk) begin
        if (csr.valid) begin
            csr.rdata <= old_val;
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

//--- rtl/lsu.sv
`timescale 1ns/100ps

module lsu import ls_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_i,
    mem_req_if.lsu            mem,
    output logic [XLEN-1:0]   paddr_o,
    output logic [XLEN-1:0]   pwdata_o,
    output logic [XLEN/8-1:0] pstrb_o,
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    input  logic [XLEN-1:0]   prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i
);
    localparam int STRB_W = XLEN / 8;
    localparam int OFF_W  = $clog2(STRB_W);

    lsu_state_e        state_q;
    logic              store_q;
    mem_op_e           op_q;
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [OFF_W-1:0]  lane;
    logic [OFF_W+2:0]  bit_sh;
    logic [STRB_W-1:0] size_mask;
    logic [XLEN-1:0]   lane_data;
    logic [XLEN-1:0]   load_val;
    logic              xfer_end;

    // ~~~~~~~~~~~~~~~~~~~~
    // APB state machine
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= LSU_IDLE;
        end else begin
            case (state_q)
                LSU_IDLE: begin
                    if (mem.valid) begin
                        state_q <= LSU_SETUP;
                    end
                end
                LSU_SETUP: state_q <= LSU_ACCESS;
                LSU_ACCESS: begin
                    if (pready_i) begin
                        state_q <= LSU_IDLE;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LSU_IDLE && mem.valid) begin
            store_q <= mem.store;
            op_q    <= mem.op;
            addr_q  <= mem.addr;
            wdata_q <= mem.wdata;
        end
    end

    assign xfer_end  = (state_q == LSU_ACCESS) && pready_i;
    assign psel_o    = (state_q != LSU_IDLE);
    assign penable_o = (state_q == LSU_ACCESS);
    assign pwrite_o  = psel_o && store_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Byte lanes
    // ~~~~~~~~~~~~~~~~~~~~

    assign lane    = addr_q[OFF_W-1:0];
    assign bit_sh  = {lane, 3'b000};
    assign paddr_o = {addr_q[XLEN-1:OFF_W], {OFF_W{1'b0}}};  // Word aligned

    always_comb begin
        case (op_q)
            MEM_B, MEM_BU: size_mask = STRB_W'(1);
            MEM_H, MEM_HU: size_mask = STRB_W'(3);
            MEM_W, MEM_WU: size_mask = STRB_W'(15);
            default:       size_mask = '1;
        endcase
    end

    assign pwdata_o = wdata_q << bit_sh;
    assign pstrb_o  = pwrite_o ? (size_mask << lane) : '0;  // Reads carry no strobes

    assign lane_data = prdata_i >> bit_sh;

    always_comb begin
        case (op_q)
            MEM_B:   load_val = XLEN'($signed(lane_data[7:0]));
            MEM_BU:  load_val = XLEN'(lane_data[7:0]);
            MEM_H:   load_val = XLEN'($signed(lane_data[15:0]));
            MEM_HU:  load_val = XLEN'(lane_data[15:0]);
            MEM_W:   load_val = XLEN'($signed(lane_data[31:0]));
            MEM_WU:  load_val = XLEN'(lane_data[31:0]);
            default: load_val = lane_data;
        endcase
    end

    assign mem.done  = xfer_end;
    assign mem.err   = xfer_end && pslverr_i;
    assign mem.rdata = store_q ? '0 : load_val;

endmodule

//--- rtl/ls_decode.sv
`timescale 1ns/100ps

module ls_decode import ls_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [31:0]     instr_i,
    input  logic            trap_i,
    input  logic [XLEN-1:0] trap_cause_i,
    input  logic            res_done_i,
    output logic            illegal_o,
    mem_req_if.decode       mem,
    csr_req_if.decode       csr
);
    opcode_e    opcode;
    mem_op_e    mem_op;
    logic [2:0] funct3;
    logic       accept;
    logic       instr_go;
    logic       busy_q;
    logic       is_mem;
    logic       is_csr;
    logic       illegal;

    assign opcode   = opcode_e'(instr_i[6:2]);
    assign funct3   = instr_i[14:12];
    assign mem_op   = mem_op_e'(funct3);
    assign accept   = in_valid_i && in_ready_o;
    assign instr_go = accept && !trap_i;  // A trap carries no instruction

    always_comb begin
        is_mem  = 1'b0;
        is_csr  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OP_LOAD: begin
                is_mem  = 1'b1;
                illegal = (funct3 == 3'd7);
            end
            OP_STORE:  is_mem = 1'b1;
            OP_SYSTEM: is_csr = 1'b1;
            default:   illegal = 1'b1;
        endcase
        // Doubleword and unsigned word accesses only exist on RV64
        if (is_mem && XLEN == 32 && (mem_op == MEM_D || mem_op == MEM_WU)) begin
            illegal = 1'b1;
        end
    end

    // Stage holds one instruction until its result has gone out
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (instr_go) begin
            busy_q <= 1'b1;
        end else if (res_done_i) begin
            busy_q <= 1'b0;
        end
    end

    assign in_ready_o = !busy_q;
    assign illegal_o  = instr_go && illegal;

    assign mem.valid = instr_go && is_mem && !illegal;
    assign mem.store = (opcode == OP_STORE);
    assign mem.op    = mem_op;
    assign mem.addr  = addr_i;
    assign mem.wdata = rs2_i;

    assign csr.valid = instr_go && is_csr;
    assign csr.op    = csr_op_e'(funct3[1:0]);
    assign csr.addr  = instr_i[31:20];
    assign csr.wdata = funct3[2] ? XLEN'(instr_i[19:15]) : addr_i;  // uimm or rs1
    assign csr.trap  = accept && trap_i;
    assign csr.cause = trap_cause_i;
    assign csr.pc    = pc_i;

endmodule

//--- rtl/ls_ifs.sv
`timescale 1ns/100ps

interface mem_req_if import ls_pkg::*; #(
    parameter int XLEN = 64
) ();
    logic            valid;  // One cycle on acceptance
    logic            store;
    mem_op_e         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            done;   // One cycle when the APB transfer ends
    logic [XLEN-1:0] rdata;  // Extended load value or zero for a store
    logic            err;

    modport decode (output valid, store, op, addr, wdata);
    modport lsu    (input valid, store, op, addr, wdata, output done, rdata, err);
    modport merge  (input done, rdata, err);
endinterface

interface csr_req_if import ls_pkg::*; #(
    parameter int XLEN = 64
) ();
    logic            valid;
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] wdata;  // rs1 value or zero-extended immediate
    logic            trap;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] pc;
    logic            done;
    logic [XLEN-1:0] rdata;

    modport decode (
        output valid, op, addr, wdata, trap, cause, pc
    );
    modport csr (
        input valid, op, addr, wdata, trap, cause, pc,
        output done, rdata
    );
    modport merge (input done, rdata);
endinterface

//--- rtl/ls_pkg.sv
package ls_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Instruction fields
    // ~~~~~~~~~~~~~~~~~~~~

    // Major opcode in instr[6:2]
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_STORE  = 5'b01000,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    // Load and store funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } mem_op_e;

    // Zicsr operation in funct3[1:0] while funct3[2] picks the immediate form
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        LSU_IDLE   = 2'b00,
        LSU_SETUP  = 2'b01,
        LSU_ACCESS = 2'b10
    } lsu_state_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Machine CSR addresses
    // ~~~~~~~~~~~~~~~~~~~~

    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

endpackage
